/* rtl/board_pkg.sv */
// Shared widths, register map and I2S slot states; import into any block that needs them
`default_nettype none

package board_pkg;

  // ******************************
  // Widths
  // ******************************

  // Bits in one audio channel word
  localparam int SAMPLE_WIDTH = 16;

  // Register data, left word in the upper half and right word in the lower half
  localparam int DATA_WIDTH = 2 * SAMPLE_WIDTH;

  // Register address, eight registers in all
  localparam int ADDR_WIDTH = 3;

  // ******************************
  // Register map
  // ******************************

  // EVT reads the sticky events, a write of one clears the matching bit
  // STAT holds tx_empty in bit 0 and rx_new in bit 1
  typedef enum logic [ADDR_WIDTH-1:0] {
    REG_GPIO_OUT   = 3'd0,
    REG_GPIO_TRI   = 3'd1,
    REG_GPIO_IN    = 3'd2,
    REG_GPIO_EVT   = 3'd3,
    REG_IRQ_MASK   = 3'd4,
    REG_AUDIO_TX   = 3'd5,
    REG_AUDIO_RX   = 3'd6,
    REG_AUDIO_STAT = 3'd7
  } reg_addr_e;

  // ******************************
  // I2S
  // ******************************

  // Which word of the stereo pair the serializer is working on
  typedef enum logic [1:0] {
    SLOT_IDLE  = 2'd0,
    SLOT_LEFT  = 2'd1,
    SLOT_RIGHT = 2'd2
  } i2s_slot_e;

endpackage

`default_nettype wire

/* rtl/gpio_pin.sv */
// One GPIO pin slice with input synchronizer and edge detect, instantiated once per bit
`default_nettype none

module gpio_pin (
  input  wire  clk,
  input  wire  rst_i,
  input  wire  tri_i,
  input  wire  pin_i,
  output logic level_o,
  output logic edge_o
);

  logic [1:0] sync_q;
  logic       prev_q;

  // Two flops bring the pad level into the clock domain
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= 2'b00;
      prev_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], pin_i};
      prev_q <= sync_q[1];
    end
  end

  assign level_o = sync_q[1];

  // Either direction of change counts as an event
  // A pin driven by the fabric (tri_i low) never reports one
  assign edge_o = tri_i & (sync_q[1] ^ prev_q);

endmodule

`default_nettype wire

/* rtl/gpio_event_collect.sv */
// Sticky GPIO event bits with write-one-to-clear and the masked interrupt output
`default_nettype none

module gpio_event_collect #(
  parameter int GPIO_WIDTH = 8
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire [GPIO_WIDTH-1:0]   edge_i,
  input  wire [GPIO_WIDTH-1:0]   clr_i,
  input  wire [GPIO_WIDTH-1:0]   mask_i,
  output logic [GPIO_WIDTH-1:0]  evt_o,
  output logic                   irq_o
);

  // ******************************
  // Event bits
  // ******************************

  // An edge in the same cycle as its clear keeps the bit set
  always_ff @(posedge clk) begin
    if (rst_i) begin
      evt_o <= '0;
    end else begin
      evt_o <= (evt_o & ~clr_i) | edge_i;
    end
  end

  // ******************************
  // Interrupt
  // ******************************

  // Registered one cycle behind the event bits
  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= |(evt_o & mask_i);
    end
  end

endmodule

`default_nettype wire

/* rtl/bus_regs.sv */
// Register port decoder holding the GPIO, mask and audio status registers of the peripheral
`default_nettype none

module bus_regs import board_pkg::*; #(
  parameter int GPIO_WIDTH = 8
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    wr_stb_i,
  input  wire                    rd_stb_i,
  input  wire [ADDR_WIDTH-1:0]   addr_i,
  input  wire [DATA_WIDTH-1:0]   wdata_i,
  output logic [DATA_WIDTH-1:0]  rdata_o,
  output logic                   rvalid_o,
  output logic [GPIO_WIDTH-1:0]  gpio_out_o,
  output logic [GPIO_WIDTH-1:0]  gpio_tri_o,
  input  wire [GPIO_WIDTH-1:0]   gpio_level_i,
  input  wire [GPIO_WIDTH-1:0]   evt_i,
  output logic [GPIO_WIDTH-1:0]  evt_clr_o,
  output logic [GPIO_WIDTH-1:0]  irq_mask_o,
  output logic                   tx_wr_o,
  output logic [DATA_WIDTH-1:0]  tx_data_o,
  input  wire                    tx_empty_i,
  input  wire                    rx_valid_i,
  input  wire [DATA_WIDTH-1:0]   rx_data_i
);

  reg_addr_e             addr;
  logic                  wr_out;
  logic                  wr_tri;
  logic                  wr_mask;
  logic                  rd_rx;
  logic                  rx_new_q;
  logic [DATA_WIDTH-1:0] rx_pair_q;
  logic [DATA_WIDTH-1:0] rd_mux;

  // ******************************
  // Address decode
  // ******************************

  assign addr    = reg_addr_e'(addr_i);
  assign wr_out  = wr_stb_i && (addr == REG_GPIO_OUT);
  assign wr_tri  = wr_stb_i && (addr == REG_GPIO_TRI);
  assign wr_mask = wr_stb_i && (addr == REG_IRQ_MASK);
  assign rd_rx   = rd_stb_i && (addr == REG_AUDIO_RX);

  // The clear vector only lives for the cycle of the write strobe
  assign evt_clr_o = (wr_stb_i && (addr == REG_GPIO_EVT)) ? wdata_i[GPIO_WIDTH-1:0] : '0;

  // A sample write goes straight to the transmit holding register
  assign tx_wr_o   = wr_stb_i && (addr == REG_AUDIO_TX);
  assign tx_data_o = wdata_i;

  // Writable registers; every pin starts out as an input
  always_ff @(posedge clk) begin
    if (rst_i) begin
      gpio_out_o <= '0;
      gpio_tri_o <= '1;
      irq_mask_o <= '0;
    end else begin
      if (wr_out) begin
        gpio_out_o <= wdata_i[GPIO_WIDTH-1:0];
      end
      if (wr_tri) begin
        gpio_tri_o <= wdata_i[GPIO_WIDTH-1:0];
      end
      if (wr_mask) begin
        irq_mask_o <= wdata_i[GPIO_WIDTH-1:0];
      end
    end
  end

  // A new pair wins over a read in the same cycle so that it is not lost
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_new_q <= 1'b0;
    end else if (rx_valid_i) begin
      rx_new_q <= 1'b1;
    end else if (rd_rx) begin
      rx_new_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid_i) begin
      rx_pair_q <= rx_data_i;
    end
  end

  // ******************************
  // Read path
  // ******************************

  // Narrow registers read back zero extended
  always_comb begin
    rd_mux = '0;
    case (addr)
      REG_GPIO_OUT:   rd_mux[GPIO_WIDTH-1:0] = gpio_out_o;
      REG_GPIO_TRI:   rd_mux[GPIO_WIDTH-1:0] = gpio_tri_o;
      REG_GPIO_IN:    rd_mux[GPIO_WIDTH-1:0] = gpio_level_i;
      REG_GPIO_EVT:   rd_mux[GPIO_WIDTH-1:0] = evt_i;
      REG_IRQ_MASK:   rd_mux[GPIO_WIDTH-1:0] = irq_mask_o;
      REG_AUDIO_RX:   rd_mux = rx_pair_q;
      REG_AUDIO_STAT: rd_mux[1:0] = {rx_new_q, tx_empty_i};
      default:        rd_mux = '0;
    endcase
  end

  // Read data is valid exactly one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_stb_i) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* rtl/i2s_clkgen.sv */
// I2S master clock generator with mclk, bclk, lrclk and the bit and frame strobes
`default_nettype none

module i2s_clkgen import board_pkg::*; #(
  parameter int BCLK_DIV = 2
) (
  input  wire  clk,
  input  wire  rst_i,
  output logic mclk_o,
  output logic bclk_o,
  output logic lrclk_o,
  output logic bit_fall_o,
  output logic bit_rise_o,
  output logic frame_o
);

  localparam int DIV_W      = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
  localparam int FRAME_BITS = 2 * SAMPLE_WIDTH;
  localparam int BIT_W      = $clog2(FRAME_BITS);

  logic [DIV_W-1:0] div_cnt_q;
  logic [BIT_W-1:0] bit_cnt_q;
  logic             div_end;

  // Each strobe is high in the cycle before bclk actually toggles, so
  // logic acting on it changes state on the same clock edge as the pin
  assign div_end    = (div_cnt_q == DIV_W'(BCLK_DIV - 1));
  assign bit_rise_o = div_end & ~bclk_o;
  assign bit_fall_o = div_end & bclk_o;

  // Frame starts on the fall that ends the last bit period of the right half
  assign frame_o = bit_fall_o & (bit_cnt_q == BIT_W'(FRAME_BITS - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mclk_o    <= 1'b0;
      bclk_o    <= 1'b0;
      lrclk_o   <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      // mclk runs at half the fabric clock
      mclk_o <= ~mclk_o;
      if (div_end) begin
        div_cnt_q <= '0;
        bclk_o    <= ~bclk_o;
      end else begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
      // Bit periods are counted on the falling edge, where lrclk also moves
      if (bit_fall_o) begin
        bit_cnt_q <= frame_o ? '0 : bit_cnt_q + 1'b1;
        if (bit_cnt_q == BIT_W'(SAMPLE_WIDTH - 1)) begin
          lrclk_o <= 1'b1;
        end else if (frame_o) begin
          lrclk_o <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/i2s_tx.sv */
// I2S transmitter with a one-pair holding register and an MSB-first serializer
`default_nettype none

module i2s_tx import board_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   wr_i,
  input  wire [DATA_WIDTH-1:0]  data_i,
  input  wire                   bit_fall_i,
  input  wire                   frame_i,
  output logic                  empty_o,
  output logic                  sdata_o
);

  localparam int CNT_W = $clog2(SAMPLE_WIDTH);

  logic [DATA_WIDTH-1:0] hold_q;
  logic [DATA_WIDTH-1:0] shift_q;
  logic                  full_q;
  logic [CNT_W-1:0]      cnt_q;
  i2s_slot_e             slot_q;

  // ******************************
  // Holding register
  // ******************************

  // A new write simply replaces an unsent pair
  always_ff @(posedge clk) begin
    if (wr_i) begin
      hold_q <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (wr_i) begin
      full_q <= 1'b1;
    end else if (bit_fall_i && frame_i) begin
      full_q <= 1'b0;
    end
  end

  assign empty_o = ~full_q;

  // ******************************
  // Serializer
  // ******************************

  // The output bit is taken from the shifter before the frame reload, which
  // gives the one bclk lag: the last right bit goes out as lrclk falls
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sdata_o <= 1'b0;
      cnt_q   <= '0;
      slot_q  <= SLOT_IDLE;
    end else if (bit_fall_i) begin
      if (slot_q != SLOT_IDLE) begin
        sdata_o <= shift_q[DATA_WIDTH-1];
      end
      if (frame_i) begin
        cnt_q  <= '0;
        slot_q <= SLOT_LEFT;
      end else if (slot_q != SLOT_IDLE) begin
        cnt_q <= cnt_q + 1'b1;
        // Head of the shifter moves into the right word here
        if (cnt_q == CNT_W'(SAMPLE_WIDTH - 1)) begin
          slot_q <= SLOT_RIGHT;
        end
      end
    end
  end

  // Without a fresh sample the frame carries silence
  always_ff @(posedge clk) begin
    if (bit_fall_i) begin
      if (frame_i) begin
        shift_q <= full_q ? hold_q : '0;
      end else begin
        shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/i2s_rx.sv */
// I2S receiver that collects a left and right word and presents the pair with a valid pulse
`default_nettype none

module i2s_rx import board_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   bit_rise_i,
  input  wire                   frame_i,
  input  wire                   lrclk_i,
  input  wire                   sdata_i,
  output logic                  valid_o,
  output logic [DATA_WIDTH-1:0] data_o
);

  localparam int CNT_W = $clog2(SAMPLE_WIDTH);

  logic [SAMPLE_WIDTH-1:0] shift_q;
  logic [SAMPLE_WIDTH-1:0] left_q;
  logic [SAMPLE_WIDTH-1:0] word;
  logic [CNT_W-1:0]        cnt_q;
  i2s_slot_e               slot_q;

  // Word including the bit sampled on this rise
  assign word = {shift_q[SAMPLE_WIDTH-2:0], sdata_i};

  always_ff @(posedge clk) begin
    if (bit_rise_i) begin
      shift_q <= word;
    end
  end

  // ******************************
  // Word tracking
  // ******************************

  // Because data lags lrclk by one bit, a word ends on the first rise after
  // lrclk has changed; the counter must then hold a full word or we resync
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      cnt_q   <= '0;
      slot_q  <= SLOT_IDLE;
    end else begin
      valid_o <= 1'b0;
      if (frame_i && (slot_q == SLOT_IDLE)) begin
        // The first rise after a frame still carries the old right LSB
        cnt_q  <= '1;
        slot_q <= SLOT_LEFT;
      end else if (bit_rise_i) begin
        cnt_q <= cnt_q + 1'b1;
        case (slot_q)
          SLOT_LEFT: begin
            if (lrclk_i) begin
              cnt_q  <= '0;
              slot_q <= (cnt_q == CNT_W'(SAMPLE_WIDTH - 1)) ? SLOT_RIGHT : SLOT_IDLE;
            end
          end
          SLOT_RIGHT: begin
            if (!lrclk_i) begin
              cnt_q   <= '0;
              valid_o <= (cnt_q == CNT_W'(SAMPLE_WIDTH - 1));
              slot_q  <= (cnt_q == CNT_W'(SAMPLE_WIDTH - 1)) ? SLOT_LEFT : SLOT_IDLE;
            end
          end
          default: begin
            cnt_q <= '0;
          end
        endcase
      end
    end
  end

  // Payload latches follow the same word boundaries
  always_ff @(posedge clk) begin
    if (bit_rise_i) begin
      if ((slot_q == SLOT_LEFT) && lrclk_i) begin
        left_q <= word;
      end
      if ((slot_q == SLOT_RIGHT) && !lrclk_i) begin
        data_o <= {left_q, word};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/board_top.sv */
// Top level of the peripheral block, wiring the register port to the GPIO bank and I2S link
`default_nettype none

module board_top import board_pkg::*; #(
  parameter int GPIO_WIDTH = 8,
  parameter int BCLK_DIV   = 2
) (
  input  wire                    clk,
  input  wire                    rst_i,
  input  wire                    wr_stb_i,
  input  wire                    rd_stb_i,
  input  wire [ADDR_WIDTH-1:0]   addr_i,
  input  wire [DATA_WIDTH-1:0]   wdata_i,
  output logic [DATA_WIDTH-1:0]  rdata_o,
  output logic                   rvalid_o,
  output logic                   irq_o,
  output logic [GPIO_WIDTH-1:0]  gpio_o,
  output logic [GPIO_WIDTH-1:0]  gpio_t_o,
  input  wire [GPIO_WIDTH-1:0]   gpio_i,
  output logic                   i2s_mclk_o,
  output logic                   i2s_bclk_o,
  output logic                   i2s_lrclk_o,
  output logic                   i2s_sdata_o,
  input  wire                    i2s_sdata_i
);

  logic [GPIO_WIDTH-1:0] gpio_level;
  logic [GPIO_WIDTH-1:0] gpio_edge;
  logic [GPIO_WIDTH-1:0] evt;
  logic [GPIO_WIDTH-1:0] evt_clr;
  logic [GPIO_WIDTH-1:0] irq_mask;
  logic                  tx_wr;
  logic [DATA_WIDTH-1:0] tx_data;
  logic                  tx_empty;
  logic                  rx_valid;
  logic [DATA_WIDTH-1:0] rx_data;
  logic                  bit_fall;
  logic                  bit_rise;
  logic                  frame;

  // ******************************
  // Register port
  // ******************************

  bus_regs #(.GPIO_WIDTH(GPIO_WIDTH)) i_bus_regs (
    .clk          (clk),
    .rst_i        (rst_i),
    .wr_stb_i     (wr_stb_i),
    .rd_stb_i     (rd_stb_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .gpio_out_o   (gpio_o),
    .gpio_tri_o   (gpio_t_o),
    .gpio_level_i (gpio_level),
    .evt_i        (evt),
    .evt_clr_o    (evt_clr),
    .irq_mask_o   (irq_mask),
    .tx_wr_o      (tx_wr),
    .tx_data_o    (tx_data),
    .tx_empty_i   (tx_empty),
    .rx_valid_i   (rx_valid),
    .rx_data_i    (rx_data)
  );

  // ******************************
  // GPIO bank
  // ******************************

  // Pad buffers sit outside this block, so each pin has out, enable and in
  for (genvar i = 0; i < GPIO_WIDTH; i++) begin : g_pin
    gpio_pin i_gpio_pin (
      .clk     (clk),
      .rst_i   (rst_i),
      .tri_i   (gpio_t_o[i]),
      .pin_i   (gpio_i[i]),
      .level_o (gpio_level[i]),
      .edge_o  (gpio_edge[i])
    );
  end

  gpio_event_collect #(.GPIO_WIDTH(GPIO_WIDTH)) i_event_collect (
    .clk    (clk),
    .rst_i  (rst_i),
    .edge_i (gpio_edge),
    .clr_i  (evt_clr),
    .mask_i (irq_mask),
    .evt_o  (evt),
    .irq_o  (irq_o)
  );

  // ******************************
  // I2S link
  // ******************************

  i2s_clkgen #(.BCLK_DIV(BCLK_DIV)) i_i2s_clkgen (
    .clk        (clk),
    .rst_i      (rst_i),
    .mclk_o     (i2s_mclk_o),
    .bclk_o     (i2s_bclk_o),
    .lrclk_o    (i2s_lrclk_o),
    .bit_fall_o (bit_fall),
    .bit_rise_o (bit_rise),
    .frame_o    (frame)
  );

  i2s_tx i_i2s_tx (
    .clk        (clk),
    .rst_i      (rst_i),
    .wr_i       (tx_wr),
    .data_i     (tx_data),
    .bit_fall_i (bit_fall),
    .frame_i    (frame),
    .empty_o    (tx_empty),
    .sdata_o    (i2s_sdata_o)
  );

  // The receiver follows the same lrclk that goes out on the pad
  i2s_rx i_i2s_rx (
    .clk        (clk),
    .rst_i      (rst_i),
    .bit_rise_i (bit_rise),
    .frame_i    (frame),
    .lrclk_i    (i2s_lrclk_o),
    .sdata_i    (i2s_sdata_i),
    .valid_o    (rx_valid),
    .data_o     (rx_data)
  );

endmodule

`default_nettype wire

/* bench/tb_board_top.sv */
// Testbench for board_top covering registers, GPIO events, I2S loopback and clock ratios
`default_nettype none

module tb_board_top import board_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int GPIO_WIDTH   = 8;
  localparam int BCLK_DIV     = 2;
  localparam int FRAME_CYCLES = 2 * SAMPLE_WIDTH * 2 * BCLK_DIV;
  localparam int OUT_ROWS     = 4;
  localparam int EVT_ROWS     = 5;
  localparam int AUDIO_ROWS   = 4;

  logic                  clk;
  logic                  rst_i;
  logic                  wr_stb_i;
  logic                  rd_stb_i;
  logic [ADDR_WIDTH-1:0] addr_i;
  logic [DATA_WIDTH-1:0] wdata_i;
  logic [DATA_WIDTH-1:0] rdata_o;
  logic                  rvalid_o;
  logic                  irq_o;
  logic [GPIO_WIDTH-1:0] gpio_o;
  logic [GPIO_WIDTH-1:0] gpio_t_o;
  logic [GPIO_WIDTH-1:0] gpio_i;
  logic                  i2s_mclk_o;
  logic                  i2s_bclk_o;
  logic                  i2s_lrclk_o;
  logic                  i2s_sdata_o;
  wire                   i2s_sdata_i;

  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;
  integer seed;
  logic   prev_bclk;
  logic   cur_bclk;
  logic   prev_lr;
  logic   cur_lr;

  // ******************************
  // Stimulus tables
  // ******************************

  // Output and direction rows, read back as written
  logic [GPIO_WIDTH-1:0] out_tbl [OUT_ROWS] = '{8'h5A, 8'hFF, 8'h00, 8'h81};
  logic [GPIO_WIDTH-1:0] dir_tbl [OUT_ROWS] = '{8'h0F, 8'h00, 8'hFF, 8'h3C};

  // Event rows: direction, input pattern, interrupt mask and partial clear
  logic [GPIO_WIDTH-1:0] tri_tbl  [EVT_ROWS] = '{8'hFF, 8'hFF, 8'h0F, 8'h3C, 8'hF0};
  logic [GPIO_WIDTH-1:0] in_tbl   [EVT_ROWS] = '{8'hA5, 8'hA4, 8'h5A, 8'hC3, 8'h00};
  logic [GPIO_WIDTH-1:0] mask_tbl [EVT_ROWS] = '{8'h00, 8'h01, 8'hF0, 8'h3C, 8'h80};
  logic [GPIO_WIDTH-1:0] clr_tbl  [EVT_ROWS] = '{8'h0F, 8'h01, 8'h03, 8'h00, 8'hF0};

  // Audio pairs are drawn at run time from the seeded generator
  logic [DATA_WIDTH-1:0] audio_tbl [AUDIO_ROWS];

  // Serial data comes straight back into the receiver
  assign i2s_sdata_i = i2s_sdata_o;

  board_top #(.GPIO_WIDTH(GPIO_WIDTH), .BCLK_DIV(BCLK_DIV)) dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .wr_stb_i    (wr_stb_i),
    .rd_stb_i    (rd_stb_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o),
    .irq_o       (irq_o),
    .gpio_o      (gpio_o),
    .gpio_t_o    (gpio_t_o),
    .gpio_i      (gpio_i),
    .i2s_mclk_o  (i2s_mclk_o),
    .i2s_bclk_o  (i2s_bclk_o),
    .i2s_lrclk_o (i2s_lrclk_o),
    .i2s_sdata_o (i2s_sdata_o),
    .i2s_sdata_i (i2s_sdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Hard stop in case a wait loop itself misbehaves
  initial begin
    #2000000;
    $display("Simulation ran past its time limit, errors so far: %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

  // ******************************
  // Helper tasks
  // ******************************

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    checks++;
    assert (expected == actual) else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Strobes are one cycle wide and launched on the falling edge
  task automatic reg_write(input reg_addr_e addr, input logic [DATA_WIDTH-1:0] data);
    @(negedge clk);
    wr_stb_i = 1'b1;
    addr_i   = addr;
    wdata_i  = data;
    @(negedge clk);
    wr_stb_i = 1'b0;
  endtask

  // Read data belongs to the cycle right after the strobe and no other
  task automatic reg_read(input reg_addr_e addr, output logic [DATA_WIDTH-1:0] data);
    @(negedge clk);
    rd_stb_i = 1'b1;
    addr_i   = addr;
    @(negedge clk);
    rd_stb_i = 1'b0;
    checks++;
    assert (rvalid_o) else begin
      $display("Read of register %0d got no response one cycle after the strobe", addr);
      errors++;
    end
    data = rvalid_o ? rdata_o : '0;
  endtask

  // Port values are sampled mid-cycle, away from the clock edge that moves them
  task automatic step_ports();
    prev_bclk = cur_bclk;
    prev_lr   = cur_lr;
    @(negedge clk);
    cur_bclk = i2s_bclk_o;
    cur_lr   = i2s_lrclk_o;
  endtask

  // Counts bclk rises until lrclk changes level
  task automatic count_half(output int rises, output logic ok);
    int waited;
    waited = 0;
    rises  = 0;
    ok     = 1'b0;
    while (!ok && waited < 2 * FRAME_CYCLES) begin
      step_ports();
      waited++;
      if (cur_bclk && !prev_bclk) begin
        rises++;
      end
      if (cur_lr != prev_lr) begin
        ok = 1'b1;
      end
    end
  endtask

  // Cycles from one bclk rise to the next
  task automatic measure_bclk(output int cycles, output logic ok);
    int waited;
    logic started;
    waited  = 0;
    cycles  = 0;
    started = 1'b0;
    ok      = 1'b0;
    while (!ok && waited < 8 * BCLK_DIV) begin
      step_ports();
      waited++;
      if (started) begin
        cycles++;
      end
      if (cur_bclk && !prev_bclk) begin
        ok      = started;
        started = 1'b1;
      end
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    logic [DATA_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0] pair;
    logic [DATA_WIDTH-1:0] prev_pair;
    logic [GPIO_WIDTH-1:0] prev_in;
    logic [GPIO_WIDTH-1:0] exp_evt;
    logic                  exp_irq;
    logic                  exp_mclk;
    logic                  ok;
    logic                  seen;
    int                    waited;
    int                    start_cnt;
    int                    rises;
    int                    cycles;

    rst_i     = 1'b1;
    wr_stb_i  = 1'b0;
    rd_stb_i  = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    gpio_i    = '0;
    cur_bclk  = 1'b0;
    cur_lr    = 1'b0;
    prev_bclk = 1'b0;
    prev_lr   = 1'b0;
    seed      = 32'hecae;
    prev_in   = '0;

    // Nonzero pairs, each unlike the one before it
    prev_pair = '0;
    for (int k = 0; k < AUDIO_ROWS; k++) begin
      pair = $random(seed);
      while (pair == '0 || pair == prev_pair) begin
        pair = $random(seed);
      end
      audio_tbl[k] = pair;
      prev_pair    = pair;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    // Reset state
    check_value("reset irq", '0, DATA_WIDTH'(irq_o));
    check_value("reset gpio_t", DATA_WIDTH'({GPIO_WIDTH{1'b1}}), DATA_WIDTH'(gpio_t_o));
    check_value("reset gpio_o", '0, DATA_WIDTH'(gpio_o));
    check_value("reset rvalid", '0, DATA_WIDTH'(rvalid_o));
    check_value("reset mclk", '0, DATA_WIDTH'(i2s_mclk_o));
    check_value("reset bclk", '0, DATA_WIDTH'(i2s_bclk_o));
    check_value("reset lrclk", '0, DATA_WIDTH'(i2s_lrclk_o));
    check_value("reset sdata", '0, DATA_WIDTH'(i2s_sdata_o));
    reg_read(REG_AUDIO_STAT, rd);
    check_value("reset audio status", DATA_WIDTH'(1), rd);

    // Output and direction registers reach the ports and read back
    for (int i = 0; i < OUT_ROWS; i++) begin
      reg_write(REG_GPIO_OUT, DATA_WIDTH'(out_tbl[i]));
      reg_write(REG_GPIO_TRI, DATA_WIDTH'(dir_tbl[i]));
      check_value("gpio_o port", DATA_WIDTH'(out_tbl[i]), DATA_WIDTH'(gpio_o));
      check_value("gpio_t port", DATA_WIDTH'(dir_tbl[i]), DATA_WIDTH'(gpio_t_o));
      reg_read(REG_GPIO_OUT, rd);
      check_value("gpio out readback", DATA_WIDTH'(out_tbl[i]), rd);
      reg_read(REG_GPIO_TRI, rd);
      check_value("gpio tri readback", DATA_WIDTH'(dir_tbl[i]), rd);
    end

    // Inputs and events, each row starting with all events cleared
    for (int i = 0; i < EVT_ROWS; i++) begin
      reg_write(REG_GPIO_TRI, DATA_WIDTH'(tri_tbl[i]));
      reg_write(REG_IRQ_MASK, DATA_WIDTH'(mask_tbl[i]));
      reg_write(REG_GPIO_EVT, DATA_WIDTH'({GPIO_WIDTH{1'b1}}));
      @(negedge clk);
      gpio_i  = in_tbl[i];
      exp_evt = (in_tbl[i] ^ prev_in) & tri_tbl[i];
      exp_irq = |(exp_evt & mask_tbl[i]);
      prev_in = in_tbl[i];
      // Two sync stages, the event flop and the interrupt flop
      repeat (4) @(negedge clk);
      check_value("gpio irq after edge", DATA_WIDTH'(exp_irq), DATA_WIDTH'(irq_o));
      reg_read(REG_GPIO_IN, rd);
      check_value("gpio input level", DATA_WIDTH'(in_tbl[i]), rd);
      reg_read(REG_GPIO_EVT, rd);
      check_value("gpio events", DATA_WIDTH'(exp_evt), rd);
      reg_write(REG_GPIO_EVT, DATA_WIDTH'(clr_tbl[i]));
      exp_evt = exp_evt & ~clr_tbl[i];
      exp_irq = |(exp_evt & mask_tbl[i]);
      reg_read(REG_GPIO_EVT, rd);
      check_value("gpio events after clear", DATA_WIDTH'(exp_evt), rd);
      check_value("gpio irq after clear", DATA_WIDTH'(exp_irq), DATA_WIDTH'(irq_o));
    end
    reg_write(REG_GPIO_EVT, DATA_WIDTH'({GPIO_WIDTH{1'b1}}));

    // Audio loopback through the serial pins
    for (int k = 0; k < AUDIO_ROWS; k++) begin
      reg_write(REG_AUDIO_TX, audio_tbl[k]);
      waited = 0;
      rd     = '0;
      while (!rd[0] && waited < 2 * FRAME_CYCLES) begin
        reg_read(REG_AUDIO_STAT, rd);
        waited = waited + 3;
      end
      checks++;
      assert (rd[0]) else begin
        $display("Transmit holding register never emptied for pair %0d", k);
        errors++;
      end
      start_cnt = cycle_cnt;
      seen      = 1'b0;
      pair      = '0;
      while (!seen && (cycle_cnt - start_cnt) < 3 * FRAME_CYCLES) begin
        reg_read(REG_AUDIO_STAT, rd);
        if (rd[1]) begin
          reg_read(REG_AUDIO_RX, pair);
          seen = (pair == audio_tbl[k]);
        end
      end
      checks++;
      assert (seen) else begin
        $display("Fail audio pair %0d: expected %h, actual %h", k, audio_tbl[k], pair);
        errors++;
      end
    end

    // Clock ratios, after lining up on an lrclk change
    step_ports();
    count_half(rises, ok);
    for (int h = 0; h < 4; h++) begin
      count_half(rises, ok);
      checks++;
      assert (ok) else begin
        $display("lrclk stopped toggling during half %0d", h);
        errors++;
      end
      check_value("bclk rises per lrclk half", DATA_WIDTH'(SAMPLE_WIDTH), DATA_WIDTH'(rises));
    end
    for (int p = 0; p < 3; p++) begin
      measure_bclk(cycles, ok);
      checks++;
      assert (ok) else begin
        $display("bclk stopped toggling");
        errors++;
      end
      check_value("bclk period", DATA_WIDTH'(2 * BCLK_DIV), DATA_WIDTH'(cycles));
    end

    // mclk flips once per fabric clock
    for (int c = 0; c < 8; c++) begin
      exp_mclk = ~i2s_mclk_o;
      @(negedge clk);
      check_value("mclk toggle", DATA_WIDTH'(exp_mclk), DATA_WIDTH'(i2s_mclk_o));
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/board_pkg.sv
rtl/gpio_pin.sv
rtl/gpio_event_collect.sv
rtl/bus_regs.sv
rtl/i2s_clkgen.sv
rtl/i2s_tx.sv
rtl/i2s_rx.sv
rtl/board_top.sv
bench/tb_board_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f src.f --top-module tb_board_top -o tb_board_top

./obj_dir/tb_board_top | tee sim.log

if grep -q "^TEST OK$" sim.log; then
  exit 0
else
  exit 1
fi
